/* uparc_isa_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// MIPS-style instruction encoding.
// Only the opcodes and funct codes of the integer execute slice
// are listed; anything else decodes as illegal.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package uparc_isa_pkg;

	localparam int OPCODE_WIDTH = 6;
	localparam int REGNO_WIDTH  = 5;
	localparam int SHAMT_WIDTH  = 5;
	localparam int FUNCT_WIDTH  = 6;
	localparam int IMM_WIDTH    = 16;

	typedef logic [REGNO_WIDTH-1:0] regno_t;

	// Primary opcodes in use.
	typedef enum logic [OPCODE_WIDTH-1:0] {
		OP_SPECIAL = 6'h00,
		OP_ADDIU   = 6'h09,
		OP_SLTI    = 6'h0a,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_XORI    = 6'h0e,
		OP_LUI     = 6'h0f
	} opcode_t;

	// Function codes under OP_SPECIAL.
	typedef enum logic [FUNCT_WIDTH-1:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_SRA  = 6'h03,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_NOR  = 6'h27,
		FN_SLT  = 6'h2a,
		FN_SLTU = 6'h2b
	} funct_t;

	typedef struct packed {
		opcode_t                 opcode;
		regno_t                  rs;
		regno_t                  rt;
		regno_t                  rd;
		logic [SHAMT_WIDTH-1:0]  shamt;
		funct_t                  funct;
	} r_fmt_t;

	typedef struct packed {
		opcode_t               opcode;
		regno_t                rs;
		regno_t                rt;
		logic [IMM_WIDTH-1:0]  imm;
	} i_fmt_t;

	// Same word, R-type or I-type field layout.
	typedef union packed {
		r_fmt_t r_view;
		i_fmt_t i_view;
	} instr_u;

endpackage

/* uparc_cpu_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Datapath types of the execute slice.
// The word width is fixed by the ISA at 32 bits.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package uparc_cpu_pkg;

	localparam int REG_WIDTH = 32;

	typedef logic [REG_WIDTH-1:0] word_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_LUI
	} alu_op_t;

	// Registered result waiting to be written back.
	typedef struct packed {
		logic        valid;
		logic [4:0]  regno;
		word_t       data;
	} wb_t;

endpackage

/* uparc_rf_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register file ports: two reads, one write.
// A write is requested by any non-zero rd.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface uparc_rf_if;
	import uparc_isa_pkg::*;
	import uparc_cpu_pkg::*;

	// Source operands.
	regno_t rs;
	word_t  rs_data;
	regno_t rt;
	word_t  rt_data;

	// Write port, zero means no write.
	regno_t rd;
	word_t  rd_data;

	modport core (
		output rs,
		output rt,
		output rd,
		output rd_data,
		input  rs_data,
		input  rt_data
	);

	modport rf (
		input  rs,
		input  rt,
		input  rd,
		input  rd_data,
		output rs_data,
		output rt_data
	);

endinterface

/* uparc_reg_file.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32 x 32-bit register file.
// Register 0 reads zero and ignores writes.
// Write data is forwarded to a same-cycle read of the same register.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module uparc_reg_file (
	input logic clk,
	input logic nrst,
	uparc_rf_if.rf rf
);
	import uparc_isa_pkg::*;
	import uparc_cpu_pkg::*;

	// Register 0 has no storage.
	word_t regs [1:31];

	// One read port with write bypass.
	function automatic word_t read_port(
		input regno_t sel,
		input regno_t wr_sel,
		input word_t  wr_data
	);
		word_t value;
		if (sel == '0)
			value = '0;
		else if (sel == wr_sel)
			value = wr_data;
		else
			value = regs[sel];
		return value;
	endfunction

	always_comb
	begin
		rf.rs_data = read_port(rf.rs, rf.rd, rf.rd_data);
		rf.rt_data = read_port(rf.rt, rf.rd, rf.rd_data);
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 1; i < 32; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (rf.rd != '0)
		begin
			regs[rf.rd] <= rf.rd_data;
		end
	end

endmodule

/* uparc_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational instruction decoder.
// Flags every encoding outside the supported set as illegal.
// Shift encodings do not check that rs is zero.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module uparc_decode (
	input  uparc_isa_pkg::instr_u   instr,
	output uparc_isa_pkg::regno_t   rs,
	output uparc_isa_pkg::regno_t   rt,
	output uparc_isa_pkg::regno_t   dest,
	output uparc_cpu_pkg::alu_op_t  alu_op,
	output logic                    use_imm,
	output uparc_cpu_pkg::word_t    imm,
	output logic [4:0]              shamt,
	output logic                    illegal
);
	import uparc_isa_pkg::*;
	import uparc_cpu_pkg::*;

	word_t imm_sext;
	word_t imm_zext;

	assign imm_sext = {{(REG_WIDTH-IMM_WIDTH){instr.i_view.imm[IMM_WIDTH-1]}}, instr.i_view.imm};
	assign imm_zext = {{(REG_WIDTH-IMM_WIDTH){1'b0}}, instr.i_view.imm};

	// Source fields sit at the same bits in both formats.
	assign rs = instr.i_view.rs;
	assign rt = instr.i_view.rt;

	always_comb
	begin
		dest    = '0;
		alu_op  = ALU_ADD;
		use_imm = 1'b1;
		imm     = imm_zext;
		shamt   = '0;
		illegal = 1'b0;
		case (instr.i_view.opcode)
		OP_SPECIAL:
		begin
			dest    = instr.r_view.rd;
			use_imm = 1'b0;
			shamt   = instr.r_view.shamt;
			case (instr.r_view.funct)
			FN_ADDU: alu_op = ALU_ADD;
			FN_SUBU: alu_op = ALU_SUB;
			FN_AND:  alu_op = ALU_AND;
			FN_OR:   alu_op = ALU_OR;
			FN_XOR:  alu_op = ALU_XOR;
			FN_NOR:  alu_op = ALU_NOR;
			FN_SLT:  alu_op = ALU_SLT;
			FN_SLTU: alu_op = ALU_SLTU;
			FN_SLL:  alu_op = ALU_SLL;
			FN_SRL:  alu_op = ALU_SRL;
			FN_SRA:  alu_op = ALU_SRA;
			default: illegal = 1'b1;
			endcase
		end
		OP_ADDIU:
		begin
			dest = instr.i_view.rt;
			imm  = imm_sext;
		end
		OP_SLTI:
		begin
			dest   = instr.i_view.rt;
			imm    = imm_sext;
			alu_op = ALU_SLT;
		end
		OP_ANDI:
		begin
			dest   = instr.i_view.rt;
			alu_op = ALU_AND;
		end
		OP_ORI:
		begin
			dest   = instr.i_view.rt;
			alu_op = ALU_OR;
		end
		OP_XORI:
		begin
			dest   = instr.i_view.rt;
			alu_op = ALU_XOR;
		end
		OP_LUI:
		begin
			dest   = instr.i_view.rt;
			alu_op = ALU_LUI;
		end
		default: illegal = 1'b1;
		endcase
	end

endmodule

/* uparc_alu.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer ALU, purely combinational.
// No overflow detection; ADD and SUB wrap.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module uparc_alu (
	input  uparc_cpu_pkg::alu_op_t  op,
	input  uparc_cpu_pkg::word_t    a,
	input  uparc_cpu_pkg::word_t    b,
	input  logic [4:0]              shamt,
	output uparc_cpu_pkg::word_t    result
);
	import uparc_cpu_pkg::*;

	logic lt_signed;
	logic lt_unsigned;

	assign lt_signed   = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	always_comb
	begin
		case (op)
		ALU_ADD:  result = a + b;
		ALU_SUB:  result = a - b;
		ALU_AND:  result = a & b;
		ALU_OR:   result = a | b;
		ALU_XOR:  result = a ^ b;
		ALU_NOR:  result = ~(a | b);
		ALU_SLT:  result = {{(REG_WIDTH-1){1'b0}}, lt_signed};
		ALU_SLTU: result = {{(REG_WIDTH-1){1'b0}}, lt_unsigned};
		// Shifts take the shift amount from the instruction, not from a.
		ALU_SLL:  result = b << shamt;
		ALU_SRL:  result = b >> shamt;
		ALU_SRA:  result = word_t'($signed(b) >>> shamt);
		ALU_LUI:  result = {b[REG_WIDTH/2-1:0], {(REG_WIDTH/2){1'b0}}};
		default:  result = '0;
		endcase
	end

endmodule

/* uparc_exec_core.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Execute slice top level.
// Result appears on wb_* one cycle after instr_valid.
// No back-pressure; a strobe is accepted every cycle.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module uparc_exec_core (
	input  logic         clk,
	input  logic         nrst,
	input  logic         instr_valid,
	input  logic [31:0]  instr,
	output logic         wb_valid,
	output logic [4:0]   wb_reg,
	output logic [31:0]  wb_data,
	output logic         illegal
);
	import uparc_isa_pkg::*;
	import uparc_cpu_pkg::*;

	regno_t   dec_rs;
	regno_t   dec_rt;
	regno_t   dec_dest;
	alu_op_t  dec_op;
	logic     dec_use_imm;
	word_t    dec_imm;
	logic [4:0] dec_shamt;
	logic     dec_illegal;
	word_t    alu_b;
	word_t    alu_result;
	wb_t      wb_q;
	logic     illegal_q;

	uparc_rf_if rf_bus ();

	uparc_decode u_decode (
		.instr   (instr),
		.rs      (dec_rs),
		.rt      (dec_rt),
		.dest    (dec_dest),
		.alu_op  (dec_op),
		.use_imm (dec_use_imm),
		.imm     (dec_imm),
		.shamt   (dec_shamt),
		.illegal (dec_illegal)
	);

	uparc_reg_file u_reg_file (
		.clk  (clk),
		.nrst (nrst),
		.rf   (rf_bus)
	);

	uparc_alu u_alu (
		.op     (dec_op),
		.a      (rf_bus.rs_data),
		.b      (alu_b),
		.shamt  (dec_shamt),
		.result (alu_result)
	);

	assign rf_bus.rs = dec_rs;
	assign rf_bus.rt = dec_rt;

	// Write port follows the pending record, rd of zero means idle.
	assign rf_bus.rd      = wb_q.valid ? wb_q.regno : '0;
	assign rf_bus.rd_data = wb_q.data;

	assign alu_b = dec_use_imm ? dec_imm : rf_bus.rt_data;

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			wb_q      <= '0;
			illegal_q <= 1'b0;
		end
		else
		begin
			wb_q.valid <= instr_valid & ~dec_illegal;
			wb_q.regno <= dec_dest;
			wb_q.data  <= alu_result;
			illegal_q  <= instr_valid & dec_illegal;
		end
	end

	assign wb_valid = wb_q.valid;
	assign wb_reg   = wb_q.regno;
	assign wb_data  = wb_q.data;
	assign illegal  = illegal_q;

endmodule

/* tb_clock_gen.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset.
// 100 ns clock, nrst low for the first 10 rising edges.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clk,
	output logic nrst
);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Release lands 5 ns after an edge, like the other inputs.
	initial
	begin
		nrst = 1'b0;
		repeat (10) @(posedge clk);
		#5;
		nrst = 1'b1;
	end

endmodule

/* uparc_exec_assertions.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Checker bound into uparc_exec_core.
// Expected outputs come from the testbench model, one cycle aligned.
// Only the first failure is kept for the summary line.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module uparc_exec_assertions (
	input logic        clk,
	input logic        nrst,
	input logic        wb_valid,
	input logic [4:0]  wb_reg,
	input logic [31:0] wb_data,
	input logic        illegal,
	input logic        exp_valid,
	input logic [4:0]  exp_reg,
	input logic [31:0] exp_data,
	input logic        exp_illegal
);

	int unsigned error_count = 0;
	string       failed_check = "";
	logic [31:0] failed_exp = '0;
	logic [31:0] failed_act = '0;

	function void record_failure(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		error_count++;
		if (error_count == 1)
		begin
			failed_check = name;
			failed_exp   = expected;
			failed_act   = actual;
		end
	endfunction

	// Quiet outputs during reset.
	reset_state: assert property (@(posedge clk)
		!nrst |-> !wb_valid && !illegal)
	else
	begin
		record_failure("reset_state", '0, {30'b0, $sampled(wb_valid), $sampled(illegal)});
		$error("Outputs not idle during reset.");
	end

	wb_valid_match: assert property (@(posedge clk) disable iff (!nrst)
		wb_valid == exp_valid)
	else
	begin
		record_failure("wb_valid", {31'b0, $sampled(exp_valid)}, {31'b0, $sampled(wb_valid)});
		$error("wb_valid differs from the model.");
	end

	wb_reg_match: assert property (@(posedge clk) disable iff (!nrst)
		exp_valid |-> wb_reg == exp_reg)
	else
	begin
		record_failure("wb_reg", {27'b0, $sampled(exp_reg)}, {27'b0, $sampled(wb_reg)});
		$error("wb_reg differs from the model.");
	end

	wb_data_match: assert property (@(posedge clk) disable iff (!nrst)
		exp_valid |-> wb_data == exp_data)
	else
	begin
		record_failure("wb_data", $sampled(exp_data), $sampled(wb_data));
		$error("wb_data differs from the model.");
	end

	// One-cycle pulse exactly where the model expects it.
	illegal_pulse: assert property (@(posedge clk) disable iff (!nrst)
		illegal == exp_illegal)
	else
	begin
		record_failure("illegal", {31'b0, $sampled(exp_illegal)}, {31'b0, $sampled(illegal)});
		$error("illegal pulse differs from the model.");
	end

endmodule

/* tb_uparc_exec.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for uparc_exec_core.
// Directed sequences first, then LFSR-built instructions.
// The register model runs in program order, which matches the DUT
// because of write forwarding.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_uparc_exec;
	import uparc_isa_pkg::*;

	localparam int NUM_DIRECTED = 37;
	localparam int NUM_RANDOM   = 400;
	localparam int CYCLE_LIMIT  = 2 * (NUM_DIRECTED + NUM_RANDOM) + 50;

	logic        clk;
	logic        nrst;
	logic        instr_valid;
	logic [31:0] instr;
	logic        wb_valid;
	logic [4:0]  wb_reg;
	logic [31:0] wb_data;
	logic        illegal;

	// Model outputs for the current cycle, and for the instruction just driven.
	logic        exp_wb_valid;
	logic [4:0]  exp_wb_reg;
	logic [31:0] exp_wb_data;
	logic        exp_illegal;
	logic        pend_valid;
	logic [4:0]  pend_reg;
	logic [31:0] pend_data;
	logic        pend_illegal;

	logic [31:0] shadow [0:31];
	logic [31:0] lfsr;
	int          cycle_count;

	tb_clock_gen clk_gen0 (
		.clk  (clk),
		.nrst (nrst)
	);

	uparc_exec_core dut0 (
		.clk         (clk),
		.nrst        (nrst),
		.instr_valid (instr_valid),
		.instr       (instr),
		.wb_valid    (wb_valid),
		.wb_reg      (wb_reg),
		.wb_data     (wb_data),
		.illegal     (illegal)
	);

	bind uparc_exec_core uparc_exec_assertions u_chk (
		.clk         (clk),
		.nrst        (nrst),
		.wb_valid    (wb_valid),
		.wb_reg      (wb_reg),
		.wb_data     (wb_data),
		.illegal     (illegal),
		.exp_valid   (tb_uparc_exec.exp_wb_valid),
		.exp_reg     (tb_uparc_exec.exp_wb_reg),
		.exp_data    (tb_uparc_exec.exp_wb_data),
		.exp_illegal (tb_uparc_exec.exp_illegal)
	);

	// Taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic random_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsr  = lfsr_step(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
		return {6'h00, rs, rt, rd, sh, funct};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [5:0] r_funct(input logic [31:0] idx);
		case (idx)
		0:       return FN_ADDU;
		1:       return FN_SUBU;
		2:       return FN_AND;
		3:       return FN_OR;
		4:       return FN_XOR;
		5:       return FN_NOR;
		6:       return FN_SLT;
		7:       return FN_SLTU;
		8:       return FN_SLL;
		9:       return FN_SRL;
		default: return FN_SRA;
		endcase
	endfunction

	function automatic logic [5:0] i_opcode(input logic [31:0] idx);
		case (idx)
		0:       return OP_ADDIU;
		1:       return OP_SLTI;
		2:       return OP_ANDI;
		3:       return OP_ORI;
		4:       return OP_XORI;
		default: return OP_LUI;
		endcase
	endfunction

	// Mostly legal encodings, with random funct and opcode fields mixed in.
	task automatic random_instr(output logic [31:0] word);
		logic [31:0] sel;
		logic [31:0] rs;
		logic [31:0] rt;
		logic [31:0] rd;
		logic [31:0] sh;
		logic [31:0] imm;
		logic [31:0] fn;
		random_bits(5, sel);
		random_bits(5, rs);
		random_bits(5, rt);
		random_bits(5, rd);
		random_bits(5, sh);
		random_bits(16, imm);
		random_bits(6, fn);
		if (sel < 32'd11)
			word = enc_r(r_funct(sel), rs[4:0], rt[4:0], rd[4:0], sh[4:0]);
		else if (sel < 32'd23)
			word = enc_i(i_opcode((sel - 32'd11) % 32'd6), rs[4:0], rt[4:0], imm[15:0]);
		else if (sel < 32'd27)
			word = enc_r(fn[5:0], rs[4:0], rt[4:0], rd[4:0], sh[4:0]);
		else
			word = {fn[5:0], rs[4:0], rt[4:0], imm[15:0]};
	endtask

	// Architectural result of one instruction from the shadow registers.
	task automatic predict(input logic valid, input logic [31:0] word);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sx;
		logic [31:0] zx;
		logic [31:0] res;
		logic [4:0]  dst;
		logic [4:0]  sh;
		logic        ok;
		a   = shadow[word[25:21]];
		b   = shadow[word[20:16]];
		sx  = {{16{word[15]}}, word[15:0]};
		zx  = {16'h0000, word[15:0]};
		sh  = word[10:6];
		dst = word[20:16];
		res = '0;
		ok  = 1'b1;
		case (word[31:26])
		OP_SPECIAL:
		begin
			dst = word[15:11];
			case (word[5:0])
			FN_ADDU: res = a + b;
			FN_SUBU: res = a - b;
			FN_AND:  res = a & b;
			FN_OR:   res = a | b;
			FN_XOR:  res = a ^ b;
			FN_NOR:  res = ~(a | b);
			FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
			FN_SLL:  res = b << sh;
			FN_SRL:  res = b >> sh;
			FN_SRA:  res = $unsigned($signed(b) >>> sh);
			default: ok = 1'b0;
			endcase
		end
		OP_ADDIU: res = a + sx;
		OP_SLTI:  res = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
		OP_ANDI:  res = a & zx;
		OP_ORI:   res = a | zx;
		OP_XORI:  res = a ^ zx;
		OP_LUI:   res = {word[15:0], 16'h0000};
		default:  ok = 1'b0;
		endcase
		pend_valid   = valid & ok;
		pend_reg     = dst;
		pend_data    = res;
		pend_illegal = valid & ~ok;
		if (valid && ok && dst != 5'd0)
			shadow[dst] = res;
	endtask

	// One clock cycle of stimulus; the previous instruction's result is now due.
	task automatic step(input logic valid, input logic [31:0] word);
		@(posedge clk);
		#5;
		exp_wb_valid = pend_valid;
		exp_wb_reg   = pend_reg;
		exp_wb_data  = pend_data;
		exp_illegal  = pend_illegal;
		instr_valid  = valid;
		instr        = word;
		predict(valid, word);
	endtask

	initial
	begin
		logic [31:0] word;
		logic [31:0] gap;
		instr_valid  = 1'b0;
		instr        = '0;
		exp_wb_valid = 1'b0;
		exp_wb_reg   = '0;
		exp_wb_data  = '0;
		exp_illegal  = 1'b0;
		pend_valid   = 1'b0;
		pend_reg     = '0;
		pend_data    = '0;
		pend_illegal = 1'b0;
		lfsr         = 32'h8d03;
		for (int i = 0; i < 32; i++)
			shadow[i] = '0;
		@(posedge nrst);

		// Every register reads zero after reset.
		for (int r = 1; r < 32; r += 2)
			step(1'b1, enc_r(FN_OR, r[4:0], 5'(r + 1), 5'd0, 5'd0));
		// Fresh registers read zero.
		step(1'b1, enc_r(FN_ADDU, 5'd2, 5'd3, 5'd1, 5'd0));
		step(1'b1, enc_r(FN_NOR, 5'd4, 5'd31, 5'd2, 5'd0));
		// Back-to-back dependent chain.
		step(1'b1, enc_i(OP_ORI, 5'd0, 5'd5, 16'h1234));
		step(1'b1, enc_i(OP_ADDIU, 5'd5, 5'd6, 16'hffff));
		step(1'b1, enc_r(FN_SUBU, 5'd6, 5'd5, 5'd7, 5'd0));
		// Writes to register 0, then reads of it.
		step(1'b1, enc_i(OP_LUI, 5'd0, 5'd0, 16'hbeef));
		step(1'b1, enc_r(FN_ADDU, 5'd0, 5'd0, 5'd8, 5'd0));
		step(1'b1, enc_r(FN_OR, 5'd2, 5'd2, 5'd0, 5'd0));
		step(1'b1, enc_r(FN_SLL, 5'd0, 5'd0, 5'd9, 5'd3));
		// Illegal opcode and funct, then check that nothing changed.
		step(1'b1, enc_i(6'h3f, 5'd5, 5'd5, 16'h0001));
		step(1'b1, enc_r(6'h3f, 5'd5, 5'd6, 5'd5, 5'd0));
		step(1'b1, enc_r(FN_ADDU, 5'd5, 5'd6, 5'd10, 5'd0));
		step(1'b0, 32'h0);
		// Sign handling in shifts and compares.
		step(1'b1, enc_i(OP_LUI, 5'd0, 5'd11, 16'h8000));
		step(1'b1, enc_r(FN_SRA, 5'd0, 5'd11, 5'd12, 5'd4));
		step(1'b1, enc_r(FN_SLT, 5'd12, 5'd5, 5'd13, 5'd0));
		step(1'b1, enc_r(FN_SLTU, 5'd12, 5'd5, 5'd14, 5'd0));
		step(1'b1, enc_i(OP_SLTI, 5'd12, 5'd15, 16'h0001));
		step(1'b1, enc_r(FN_SRL, 5'd0, 5'd12, 5'd16, 5'd8));
		step(1'b1, enc_i(OP_XORI, 5'd16, 5'd17, 16'hf0f0));
		step(1'b1, enc_i(OP_ANDI, 5'd17, 5'd18, 16'h0ff0));

		for (int n = 0; n < NUM_RANDOM; n++)
		begin
			random_instr(word);
			random_bits(2, gap);
			if (gap[1:0] == 2'b00)
				step(1'b0, 32'h0);
			step(1'b1, word);
		end

		// Let the last result reach the checker.
		step(1'b0, 32'h0);
		step(1'b0, 32'h0);
		@(negedge clk);
		#1;
		if (dut0.u_chk.error_count != 0)
		begin
			$display("Done: errors found");
			$fatal(1, "Assertion failures were recorded.");
		end
		else
		begin
			$display("Done: no errors");
			$finish;
		end
	end

	// Stop at the first recorded assertion failure.
	always @(negedge clk)
	begin
		if (dut0.u_chk.error_count != 0)
		begin
			$display("FAIL %s: expected %h, actual %h", dut0.u_chk.failed_check,
				dut0.u_chk.failed_exp, dut0.u_chk.failed_act);
			$display("Done: errors found");
			$fatal(1, "Stopped at the first failed assertion.");
		end
	end

	initial
		cycle_count = 0;

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT)
		begin
			$display("Timeout: the run did not finish within %0d cycles.", CYCLE_LIMIT);
			$display("Done: errors found");
			$fatal(1, "Cycle limit reached.");
		end
	end

endmodule

/* uparc_exec.f */
uparc_isa_pkg.sv
uparc_cpu_pkg.sv
uparc_rf_if.sv
uparc_reg_file.sv
uparc_decode.sv
uparc_alu.sv
uparc_exec_core.sv
tb_clock_gen.sv
uparc_exec_assertions.sv
tb_uparc_exec.sv

/* Makefile */
# Verilator build and run of the execute slice testbench.
# Pass or fail is decided by searching the log for the pass line.

VERILATOR ?= verilator
TOP       ?= tb_uparc_exec
FILELIST  ?= uparc_exec.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) $(RUN_ARGS) 2>&1 | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
